// ==== dv/interdevice_link_assertions.sv ====
// -----------------------------------------------
// link handshake and drop counter checks bound
// into every interdevice_controller instance
// -----------------------------------------------
module interdevice_link_assertions (
    input logic                   cpuclk,
    input logic                   rst,
    input types_pkg::flit_t       link_tx_flit,
    input logic                   link_tx_valid,
    input logic                   link_tx_ready,
    input types_pkg::flit_t       rx_flit,
    input logic                   rx_valid,
    input types_pkg::drop_count_t drop_count
);

    // xor of the six header and payload bytes of the delivered flit
    logic [47:0] rx_body;
    logic [7:0]  rx_fold;

    assign rx_body = {rx_flit.header, rx_flit.payload};
    assign rx_fold = rx_body[47:40] ^ rx_body[39:32] ^ rx_body[31:24]
                   ^ rx_body[23:16] ^ rx_body[15:8] ^ rx_body[7:0];

    // stalled link flit stays offered
    link_valid_held: assert property (@(posedge cpuclk) disable iff (rst)
        link_tx_valid && !link_tx_ready |=> link_tx_valid)
        else $error("link_tx_valid dropped before link_tx_ready");

    // and does not change while it waits
    link_flit_stable: assert property (@(posedge cpuclk) disable iff (rst)
        link_tx_valid && !link_tx_ready |=> $stable(link_tx_flit))
        else $error("link_tx_flit changed while stalled");

    // only good flits reach the rx queue
    rx_checksum_good: assert property (@(posedge cpuclk) disable iff (rst)
        rx_valid |-> (rx_fold == rx_flit.checksum))
        else $error("rx_valid with bad checksum 0x%h", rx_flit.checksum);

    // counter only moves up between resets
    drop_count_rises: assert property (@(posedge cpuclk) disable iff (rst)
        1'b1 |=> (drop_count >= $past(drop_count)))
        else $error("drop_count fell to 0x%h", drop_count);

endmodule

bind interdevice_controller interdevice_link_assertions u_link_assertions (
    .cpuclk        (cpuclk),
    .rst           (rst),
    .link_tx_flit  (link_tx_flit),
    .link_tx_valid (link_tx_valid),
    .link_tx_ready (link_tx_ready),
    .rx_flit       (rx_flit),
    .rx_valid      (rx_valid),
    .drop_count    (drop_count)
);

// ==== dv/tb_interdevice_link.sv ====
// -----------------------------------------------
// random two-way traffic over the link checked
// against one expected flit queue per direction
// -----------------------------------------------
module tb_interdevice_link;

    localparam int CLK_PERIOD   = 40;
    localparam int N_ONE_WAY    = 40;
    localparam int N_TWO_WAY    = 60;
    localparam int N_FILTER     = 400;
    localparam int N_STALL      = 100;
    // both directions counted
    localparam int N_TOTAL      = N_ONE_WAY + 2 * N_TWO_WAY + N_FILTER + 2 * N_STALL;
    localparam int DRAIN_CYCLES = 200;

    logic cpuclk = 1'b0;
    logic rst;
    // index 0 is host a and 1 is host b
    types_pkg::node_id_t    node_id    [2];
    types_pkg::flit_t       tx_flit    [2];
    logic                   tx_valid   [2];
    logic                   tx_ready   [2];
    types_pkg::flit_t       rx_flit    [2];
    logic                   rx_valid   [2];
    logic                   rx_ready   [2];
    types_pkg::drop_count_t drop_count [2];

    // expected deliveries per receiving host
    types_pkg::flit_t       exp_a [$];
    types_pkg::flit_t       exp_b [$];
    types_pkg::drop_count_t exp_drop [2] = '{8'h00, 8'h00};
    logic [7:0] seq_num [2] = '{8'h00, 8'h00};
    logic       tx_fired [2];
    logic       stall_en = 1'b0;
    integer     seed = 32'hc23b6b9c;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;

    interdevice_link_top uut (
        .cpuclk (cpuclk), .rst (rst),
        .node_id_a (node_id[0]), .node_id_b (node_id[1]),
        .a_tx_flit (tx_flit[0]), .a_tx_valid (tx_valid[0]), .a_tx_ready (tx_ready[0]),
        .a_rx_flit (rx_flit[0]), .a_rx_valid (rx_valid[0]), .a_rx_ready (rx_ready[0]),
        .a_drop_count (drop_count[0]),
        .b_tx_flit (tx_flit[1]), .b_tx_valid (tx_valid[1]), .b_tx_ready (tx_ready[1]),
        .b_rx_flit (rx_flit[1]), .b_rx_valid (rx_valid[1]), .b_rx_ready (rx_ready[1]),
        .b_drop_count (drop_count[1])
    );

    always #(CLK_PERIOD / 2) cpuclk = ~cpuclk;

    function automatic string side_name(input int s);
        return (s == 0) ? "a" : "b";
    endfunction

    // xor of the two header bytes and four payload bytes
    function automatic logic [7:0] fold_checksum(input types_pkg::flit_t f);
        logic [47:0] body;
        logic [7:0]  acc;
        body = {f.header, f.payload};
        acc = 8'h00;
        for (int i = 0; i < 6; i++) begin
            acc = acc ^ body[i * 8 +: 8];
        end
        return acc;
    endfunction

    // kind 0 good, 1 bad checksum, 2 wrong dst, 3 broadcast
    function automatic types_pkg::flit_t make_flit(input int s, input logic mixed);
        types_pkg::flit_t f;
        logic [1:0]       kind;
        f.header.dst_id = node_id[1 - s];
        f.header.src_id = node_id[s];
        f.header.seq    = seq_num[s];
        f.payload       = $random(seed);
        seq_num[s] = seq_num[s] + 8'd1;
        kind = mixed ? 2'($random(seed)) : 2'd0;
        if (kind == 2'd2) begin
            f.header.dst_id = 4'($random(seed));
            // never the peer so always a miss
            if (f.header.dst_id == node_id[1 - s]) begin
                f.header.dst_id = node_id[s];
            end
        end else if (kind == 2'd3) begin
            f.header.dst_id = types_pkg::BROADCAST_ID;
        end
        f.checksum = fold_checksum(f);
        if (kind == 2'd1) begin
            f.checksum = f.checksum ^ (8'($random(seed)) | 8'h01);
        end
        return f;
    endfunction

    // delivery rule decides queue entry or peer drop
    task automatic record_sent(input int s, input types_pkg::flit_t f);
        int d;
        d = 1 - s;
        if ((fold_checksum(f) == f.checksum) && (f.header.dst_id == node_id[d])
                && (f.header.dst_id != types_pkg::BROADCAST_ID)) begin
            if (d == 0) begin
                exp_a.push_back(f);
            end else begin
                exp_b.push_back(f);
            end
        end else if (exp_drop[d] != 8'hFF) begin
            exp_drop[d] = exp_drop[d] + 8'd1;
        end
    endtask

    task automatic check_received(input int s, input types_pkg::flit_t f);
        types_pkg::flit_t want;
        int               pending;
        checks++;
        pending = (s == 0) ? exp_a.size() : exp_b.size();
        if (pending == 0) begin
            $display("host %s got a flit that was never sent: 0x%h", side_name(s), f);
            errors++;
        end else begin
            if (s == 0) begin
                want = exp_a.pop_front();
            end else begin
                want = exp_b.pop_front();
            end
            if (f !== want) begin
                $display("Error: %s_rx_flit = 0x%h, expected 0x%h", side_name(s), f, want);
                errors++;
            end
        end
    endtask

    // transfers seen on the rising edge before any flop update
    always @(posedge cpuclk) begin
        for (int s = 0; s < 2; s++) begin
            tx_fired[s] = !rst && tx_valid[s] && tx_ready[s];
            if (tx_fired[s]) begin
                record_sent(s, tx_flit[s]);
            end
            if (!rst && rx_valid[s] && rx_ready[s]) begin
                check_received(s, rx_flit[s]);
            end
        end
    end

    // host rx_ready goes random while stalling is on
    initial begin
        rx_ready[0] = 1'b1;
        rx_ready[1] = 1'b1;
        forever begin
            @(negedge cpuclk);
            for (int s = 0; s < 2; s++) begin
                rx_ready[s] = !stall_en || (($random(seed) & 1) != 0);
            end
        end
    end

    // each flit held until taken with random gaps between
    task automatic drive_side(input int s, input int n, input logic mixed);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(negedge cpuclk);
            if (tx_valid[s] && tx_fired[s]) begin
                sent++;
                tx_valid[s] = 1'b0;
            end
            if (!tx_valid[s] && (sent < n) && (($random(seed) & 3) != 0)) begin
                tx_flit[s]  = make_flit(s, mixed);
                tx_valid[s] = 1'b1;
            end
        end
    endtask

    // wait for the model to settle and compare drop counts
    task automatic finish_test(input int num, input string name, input int err_before);
        int waited;
        waited = 0;
        while (((exp_a.size() != 0) || (exp_b.size() != 0) || (drop_count[0] != exp_drop[0])
                || (drop_count[1] != exp_drop[1])) && (waited < DRAIN_CYCLES)) begin
            @(negedge cpuclk);
            waited++;
        end
        if ((exp_a.size() != 0) || (exp_b.size() != 0)) begin
            $display("flits never arrived: %0d missing at a, %0d at b",
                     exp_a.size(), exp_b.size());
            errors++;
        end
        for (int s = 0; s < 2; s++) begin
            checks++;
            if (drop_count[s] != exp_drop[s]) begin
                $display("Error: %s_drop_count = 0x%h, expected 0x%h",
                         side_name(s), drop_count[s], exp_drop[s]);
                errors++;
            end
        end
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_before);
        end
    endtask

    initial begin
        int e0;
        int waited;
        rst = 1'b1;
        node_id[0] = 4'h3;
        node_id[1] = 4'hA;
        for (int s = 0; s < 2; s++) begin
            tx_flit[s]  = '0;
            tx_valid[s] = 1'b0;
        end
        repeat (8) @(posedge cpuclk);
        @(negedge cpuclk);
        rst = 1'b0;

        // test 1 quiet after reset
        e0 = errors;
        @(negedge cpuclk);
        for (int s = 0; s < 2; s++) begin
            checks++;
            if (rx_valid[s] !== 1'b0) begin
                $display("Error: %s_rx_valid = 0x%h, expected 0x0", side_name(s), rx_valid[s]);
                errors++;
            end
            // empty transmit queue takes a flit
            checks++;
            if (tx_ready[s] !== 1'b1) begin
                $display("Error: %s_tx_ready = 0x%h, expected 0x1", side_name(s), tx_ready[s]);
                errors++;
            end
        end
        finish_test(1, "reset state", e0);

        // test 2 a to b with the first flit timed from its transfer edge
        e0 = errors;
        tx_flit[0]  = make_flit(0, 1'b0);
        tx_valid[0] = 1'b1;
        @(negedge cpuclk);
        tx_valid[0] = 1'b0;
        if (!tx_fired[0]) begin
            $display("first flit was not taken by an empty transmit queue");
            errors++;
        end
        waited = 0;
        while (!rx_valid[1] && (waited < DRAIN_CYCLES)) begin
            @(posedge cpuclk);
            waited++;
        end
        checks++;
        if (waited != 2) begin
            $display("Error: b_rx_valid latency = 0x%h cycles, expected 0x2", waited);
            errors++;
        end
        drive_side(0, N_ONE_WAY - 1, 1'b0);
        finish_test(2, "a to b in order", e0);

        // test 3 both directions at once
        e0 = errors;
        fork
            drive_side(0, N_TWO_WAY, 1'b0);
            drive_side(1, N_TWO_WAY, 1'b0);
        join
        finish_test(3, "two-way traffic", e0);

        // test 4 mostly bad flits to saturate b's counter
        e0 = errors;
        drive_side(0, N_FILTER, 1'b1);
        if (exp_drop[1] != 8'hFF) begin
            $display("filter test ended before the drop counter saturated");
            errors++;
        end
        finish_test(4, "checksum and dst filter", e0);

        // test 5 random host stalls on both sides
        e0 = errors;
        stall_en = 1'b1;
        fork
            drive_side(0, N_STALL, 1'b0);
            drive_side(1, N_STALL, 1'b0);
        join
        finish_test(5, "back-pressure", e0);
        stall_en = 1'b0;

        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // twenty cycles per flit over all tests
    initial begin
        #(N_TOTAL * 20 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, traffic stalled", N_TOTAL * 20);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the link testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_interdevice_link -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// ==== src.f ====
verilog/types_pkg.sv
verilog/calculate_checksum_comb.sv
verilog/flit_fifo.sv
verilog/interdevice_controller.sv
verilog/device_port.sv
verilog/interdevice_link_top.sv
dv/interdevice_link_assertions.sv
dv/tb_interdevice_link.sv

// ==== verilog/calculate_checksum_comb.sv ====
// -----------------------------------------------
// combinational checksum check of one flit
// -----------------------------------------------
module calculate_checksum_comb (
    input  types_pkg::flit_t flit_in,
    output logic             is_valid
);

    // running xor over header and payload bytes
    logic [7:0] header_fold;
    logic [7:0] payload_fold;
    logic [7:0] folded;

    // header: {dst_id, src_id} byte and seq byte
    assign header_fold = flit_in.header[15:8] ^ flit_in.header[7:0];

    // payload: four bytes
    assign payload_fold = flit_in.payload[31:24]
                        ^ flit_in.payload[23:16]
                        ^ flit_in.payload[15:8]
                        ^ flit_in.payload[7:0];

    assign folded = header_fold ^ payload_fold;

    // good flit when the carried byte matches the fold
    assign is_valid = (folded == flit_in.checksum);

endmodule

// ==== verilog/device_port.sv ====
// -----------------------------------------------
// one device's link attachment: tx queue,
// controller, rx queue
// -----------------------------------------------
module device_port (
    input  logic                   cpuclk,
    input  logic                   rst,
    input  types_pkg::node_id_t    this_node_id,
    // host transmit
    input  types_pkg::flit_t       tx_flit,
    input  logic                   tx_valid,
    output logic                   tx_ready,
    // host receive
    output types_pkg::flit_t       rx_flit,
    output logic                   rx_valid,
    input  logic                   rx_ready,
    // link toward the peer
    output types_pkg::flit_t       link_tx_flit,
    output logic                   link_tx_valid,
    input  logic                   link_tx_ready,
    // link from the peer
    input  types_pkg::flit_t       link_rx_flit,
    input  logic                   link_rx_valid,
    output logic                   link_rx_ready,
    output types_pkg::drop_count_t drop_count
);

    // tx queue head into the controller
    types_pkg::flit_t tx_q_flit;
    logic             tx_q_valid;
    logic             tx_q_ready;

    // controller into the rx queue
    types_pkg::flit_t rx_q_flit;
    logic             rx_q_valid;
    logic             rx_q_ready;

    // host side buffering, one cycle to link valid
    flit_fifo #(
        .DEPTH (types_pkg::FIFO_DEPTH)
    ) u_tx_fifo (
        .cpuclk    (cpuclk),
        .rst       (rst),
        .in_flit   (tx_flit),
        .in_valid  (tx_valid),
        .in_ready  (tx_ready),
        .out_flit  (tx_q_flit),
        .out_valid (tx_q_valid),
        .out_ready (tx_q_ready)
    );

    interdevice_controller u_ctrl (
        .cpuclk        (cpuclk),
        .rst           (rst),
        .this_node_id  (this_node_id),
        .tx_flit       (tx_q_flit),
        .tx_valid      (tx_q_valid),
        .tx_ready      (tx_q_ready),
        .rx_flit       (rx_q_flit),
        .rx_valid      (rx_q_valid),
        .rx_ready      (rx_q_ready),
        .link_rx_flit  (link_rx_flit),
        .link_rx_valid (link_rx_valid),
        .link_rx_ready (link_rx_ready),
        .link_tx_flit  (link_tx_flit),
        .link_tx_valid (link_tx_valid),
        .link_tx_ready (link_tx_ready),
        .drop_count    (drop_count)
    );

    // absorbs host rx stalls before they reach the link
    flit_fifo #(
        .DEPTH (types_pkg::FIFO_DEPTH)
    ) u_rx_fifo (
        .cpuclk    (cpuclk),
        .rst       (rst),
        .in_flit   (rx_q_flit),
        .in_valid  (rx_q_valid),
        .in_ready  (rx_q_ready),
        .out_flit  (rx_flit),
        .out_valid (rx_valid),
        .out_ready (rx_ready)
    );

endmodule

// ==== verilog/flit_fifo.sv ====
// -----------------------------------------------
// flit queue with valid/ready on both sides
// output appears one cycle after a write
// -----------------------------------------------
module flit_fifo #(
    parameter int DEPTH = types_pkg::FIFO_DEPTH
) (
    input  logic             cpuclk,
    input  logic             rst,
    // write side
    input  types_pkg::flit_t in_flit,
    input  logic             in_valid,
    output logic             in_ready,
    // read side
    output types_pkg::flit_t out_flit,
    output logic             out_valid,
    input  logic             out_ready
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] count_t;

    // flit storage
    types_pkg::flit_t mem [DEPTH];

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;

    logic full;
    logic wr_en;
    logic rd_en;

    // wrap at DEPTH-1 for any depth
    function automatic ptr_t next_ptr(input ptr_t ptr);
        if (ptr == ptr_t'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + ptr_t'(1);
    endfunction

    assign full = (count == count_t'(DEPTH));

    // full queue still takes a write when the head leaves this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = (count != '0);
    assign out_flit  = mem[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge cpuclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    // pointers and occupancy
    always_ff @(posedge cpuclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous read and write leaves count alone
            case ({wr_en, rd_en})
                2'b10:   count <= count + count_t'(1);
                2'b01:   count <= count - count_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/interdevice_controller.sv ====
// -----------------------------------------------
// link endpoint: forwards outgoing flits and
// filters incoming ones by checksum and dst
// -----------------------------------------------
module interdevice_controller (
    input  logic                  cpuclk,
    input  logic                  rst,
    input  types_pkg::node_id_t   this_node_id,
    // local outgoing side
    input  types_pkg::flit_t      tx_flit,
    input  logic                  tx_valid,
    output logic                  tx_ready,
    // local incoming side
    output types_pkg::flit_t      rx_flit,
    output logic                  rx_valid,
    input  logic                  rx_ready,
    // direct flit connection from the peer
    input  types_pkg::flit_t      link_rx_flit,
    input  logic                  link_rx_valid,
    output logic                  link_rx_ready,
    // direct flit connection to the peer
    output types_pkg::flit_t      link_tx_flit,
    output logic                  link_tx_valid,
    input  logic                  link_tx_ready,
    output types_pkg::drop_count_t drop_count
);

    logic checksum_ok;
    logic is_for_this_node;
    logic accept;
    logic drop_event;

    calculate_checksum_comb u_rx_checksum (
        .flit_in  (link_rx_flit),
        .is_valid (checksum_ok)
    );

    // tx path is a straight pass to the peer
    assign link_tx_flit  = tx_flit;
    assign link_tx_valid = tx_valid;
    assign tx_ready      = link_tx_ready;

    // broadcast id is never ours on a point-to-point link
    assign is_for_this_node = (link_rx_flit.header.dst_id == this_node_id)
                           && (link_rx_flit.header.dst_id != types_pkg::BROADCAST_ID);
    assign accept = checksum_ok && is_for_this_node;

    // rx flit always forwarded, only valid is gated
    assign rx_flit       = link_rx_flit;
    assign rx_valid      = link_rx_valid && accept;
    assign link_rx_ready = rx_ready;

    // consumed off the link but not delivered
    assign drop_event = link_rx_valid && link_rx_ready && !accept;

    // saturating drop counter
    always_ff @(posedge cpuclk) begin
        if (rst) begin
            drop_count <= '0;
        end else if (drop_event && (drop_count != types_pkg::DROP_COUNT_MAX)) begin
            drop_count <= drop_count + 8'd1;
        end
    end

endmodule

// ==== verilog/interdevice_link_top.sv ====
// -----------------------------------------------
// two device ports joined back to back by a
// direct flit connection
// -----------------------------------------------
module interdevice_link_top (
    input  logic                   cpuclk,
    input  logic                   rst,
    input  types_pkg::node_id_t    node_id_a,
    input  types_pkg::node_id_t    node_id_b,
    // host a
    input  types_pkg::flit_t       a_tx_flit,
    input  logic                   a_tx_valid,
    output logic                   a_tx_ready,
    output types_pkg::flit_t       a_rx_flit,
    output logic                   a_rx_valid,
    input  logic                   a_rx_ready,
    output types_pkg::drop_count_t a_drop_count,
    // host b
    input  types_pkg::flit_t       b_tx_flit,
    input  logic                   b_tx_valid,
    output logic                   b_tx_ready,
    output types_pkg::flit_t       b_rx_flit,
    output logic                   b_rx_valid,
    input  logic                   b_rx_ready,
    output types_pkg::drop_count_t b_drop_count
);

    // a to b crossing
    types_pkg::flit_t a_to_b_flit;
    logic             a_to_b_valid;
    logic             a_to_b_ready;

    // b to a crossing
    types_pkg::flit_t b_to_a_flit;
    logic             b_to_a_valid;
    logic             b_to_a_ready;

    device_port u_port_a (
        .cpuclk        (cpuclk),
        .rst           (rst),
        .this_node_id  (node_id_a),
        .tx_flit       (a_tx_flit),
        .tx_valid      (a_tx_valid),
        .tx_ready      (a_tx_ready),
        .rx_flit       (a_rx_flit),
        .rx_valid      (a_rx_valid),
        .rx_ready      (a_rx_ready),
        .link_tx_flit  (a_to_b_flit),
        .link_tx_valid (a_to_b_valid),
        .link_tx_ready (a_to_b_ready),
        .link_rx_flit  (b_to_a_flit),
        .link_rx_valid (b_to_a_valid),
        .link_rx_ready (b_to_a_ready),
        .drop_count    (a_drop_count)
    );

    // tx of one side lands on rx of the other
    device_port u_port_b (
        .cpuclk        (cpuclk),
        .rst           (rst),
        .this_node_id  (node_id_b),
        .tx_flit       (b_tx_flit),
        .tx_valid      (b_tx_valid),
        .tx_ready      (b_tx_ready),
        .rx_flit       (b_rx_flit),
        .rx_valid      (b_rx_valid),
        .rx_ready      (b_rx_ready),
        .link_tx_flit  (b_to_a_flit),
        .link_tx_valid (b_to_a_valid),
        .link_tx_ready (b_to_a_ready),
        .link_rx_flit  (a_to_b_flit),
        .link_rx_valid (a_to_b_valid),
        .link_rx_ready (a_to_b_ready),
        .drop_count    (b_drop_count)
    );

endmodule

// ==== verilog/types_pkg.sv ====
// -----------------------------------------------
// flit, node id and queue definitions shared by
// both device ports of the link
// -----------------------------------------------
package types_pkg;

    // node identifier on the network
    typedef logic [3:0] node_id_t;

    // reserved id, never delivered over the point-to-point link
    localparam node_id_t BROADCAST_ID = 4'hF;

    // routing header, two bytes
    typedef struct packed {
        node_id_t   dst_id;
        node_id_t   src_id;
        logic [7:0] seq;
    } flit_header_t;

    // full flit, 56 bits
    // checksum = xor of the two header bytes and four payload bytes
    typedef struct packed {
        flit_header_t header;
        logic [31:0]  payload;
        logic [7:0]   checksum;
    } flit_t;

    // rejected flit counter, saturating
    typedef logic [7:0] drop_count_t;

    // counter stops here
    localparam drop_count_t DROP_COUNT_MAX = 8'hFF;

    // default queue depth for transmit and receive buffering
    localparam int FIFO_DEPTH = 4;

endpackage
